//--- pixel_filter_consts.svh
`ifndef PIXEL_FILTER_CONSTS_SVH
`define PIXEL_FILTER_CONSTS_SVH

// channel widths
`define PF_CHAN_W   8
`define PF_OUT_W    4
// signed working width, covers -255 .. 510
`define PF_WIDE_W   10
`define PF_MODE_W   4

// saturation ceiling of one 8-bit channel
`define PF_CHAN_MAX 255

// point operation codes, 8..15 fall through to passthrough
`define PF_MODE_GRAY   4'd0
`define PF_MODE_BRIGHT 4'd1
`define PF_MODE_DARK   4'd2
`define PF_MODE_INVERT 4'd3
`define PF_MODE_RED    4'd4
`define PF_MODE_BLUE   4'd5
`define PF_MODE_GREEN  4'd6
`define PF_MODE_PASS   4'd7

`endif

//--- pixel_filter_pkg.sv
`default_nettype none

`include "pixel_filter_consts.svh"

package pixel_filter_pkg;

   ////////////////////////////////////////
   // scalar widths
   ////////////////////////////////////////

   typedef logic [`PF_CHAN_W-1:0]        chan_t;
   typedef logic [`PF_OUT_W-1:0]         out_chan_t;
   // signed, room for overflow and underflow
   typedef logic signed [`PF_WIDE_W-1:0] wide_t;
   typedef logic [`PF_MODE_W-1:0]        mode_t;

   ////////////////////////////////////////
   // bundles
   ////////////////////////////////////////

   // blue in the high byte, red in the low byte
   typedef struct packed {
      chan_t blue;
      chan_t green;
      chan_t red;
   } rgb_t;

   // blank_n low marks a pixel outside the visible area
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank_n;
   } sync_t;

   // one-hot operation flags
   // chan_sel bit 2 red, bit 1 green, bit 0 blue
   typedef struct packed {
      logic       do_gray;
      logic       do_add;
      logic       do_sub;
      logic       do_invert;
      logic [2:0] chan_sel;
   } op_ctrl_t;

   // decode stage output
   typedef struct packed {
      logic     valid;
      sync_t    sync;
      rgb_t     pixel;
      op_ctrl_t op;
      chan_t    level;
   } decoded_t;

   // unclamped channel results, same order as rgb_t
   typedef struct packed {
      wide_t blue;
      wide_t green;
      wide_t red;
   } wide_rgb_t;

   // execute stage output
   typedef struct packed {
      logic      valid;
      sync_t     sync;
      wide_rgb_t rgb;
   } executed_t;

   // 4-bit colour towards the DAC
   typedef struct packed {
      out_chan_t red;
      out_chan_t green;
      out_chan_t blue;
   } rgb_out_t;

endpackage

`default_nettype wire

//--- filter_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "pixel_filter_consts.svh"

module filter_decode (
   input  wire logic                      clock,
   input  wire logic                      reset,
   input  wire logic                      valid_i,
   input  wire pixel_filter_pkg::mode_t   mode_i,
   input  wire pixel_filter_pkg::chan_t   level_i,
   input  wire pixel_filter_pkg::rgb_t    pixel_i,
   input  wire pixel_filter_pkg::sync_t   sync_i,
   output pixel_filter_pkg::decoded_t     dec_o
);

   import pixel_filter_pkg::*;

   // operation flags for the current mode
   op_ctrl_t op_nxt;

   ////////////////////////////////////////
   // mode decode
   ////////////////////////////////////////

   always_comb begin
      // default is passthrough, no flag set
      op_nxt = '0;
      case (mode_i)
         `PF_MODE_GRAY: begin
            op_nxt.do_gray = 1'b1;
         end
         `PF_MODE_BRIGHT: begin
            // all three channels brightened
            op_nxt.do_add   = 1'b1;
            op_nxt.chan_sel = 3'b111;
         end
         `PF_MODE_DARK: begin
            op_nxt.do_sub   = 1'b1;
            op_nxt.chan_sel = 3'b111;
         end
         `PF_MODE_INVERT: begin
            op_nxt.do_invert = 1'b1;
         end
         `PF_MODE_RED: begin
            // red only
            op_nxt.do_sub   = 1'b1;
            op_nxt.chan_sel = 3'b100;
         end
         `PF_MODE_BLUE: begin
            // blue only
            op_nxt.do_sub   = 1'b1;
            op_nxt.chan_sel = 3'b001;
         end
         `PF_MODE_GREEN: begin
            // green only
            op_nxt.do_sub   = 1'b1;
            op_nxt.chan_sel = 3'b010;
         end
         `PF_MODE_PASS: begin
            op_nxt = '0;
         end
         default: begin
            // old convolution codes, pass the pixel untouched
            op_nxt = '0;
         end
      endcase
   end

   ////////////////////////////////////////
   // stage register
   ////////////////////////////////////////

   // valid and sync carry timing, cleared on reset
   always_ff @(posedge clock) begin
      if (reset) begin
         dec_o.valid <= 1'b0;
         dec_o.sync  <= '0;
      end else begin
         dec_o.valid <= valid_i;
         dec_o.sync  <= sync_i;
      end
   end

   // payload, loaded every cycle
   always_ff @(posedge clock) begin
      dec_o.pixel <= pixel_i;
      dec_o.op    <= op_nxt;
      dec_o.level <= level_i;
   end

endmodule

`default_nettype wire

//--- filter_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "pixel_filter_consts.svh"

module filter_execute (
   input  wire logic                      clock,
   input  wire logic                      reset,
   input  wire pixel_filter_pkg::decoded_t dec_i,
   output pixel_filter_pkg::executed_t    exe_o
);

   import pixel_filter_pkg::*;

   // luma shared by all three channels
   wide_t     luma;
   // per-channel results before clamping
   wide_rgb_t rgb_nxt;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // zero extend into the signed working width
   function automatic wide_t widen(input chan_t c);
      widen = wide_t'({2'b00, c});
   endfunction

   // one channel of the selected point operation
   // sel marks this channel for add or subtract
   function automatic wide_t point_op(
      input chan_t    c,
      input logic     sel,
      input op_ctrl_t op,
      input chan_t    level,
      input wide_t    gray
   );
      wide_t v;
      wide_t lv;
      v  = widen(c);
      lv = widen(level);
      if (op.do_gray) begin
         point_op = gray;
      end else if (op.do_invert) begin
         point_op = wide_t'(`PF_CHAN_MAX) - v;
      end else if (op.do_add && sel) begin
         // may exceed 255, clamped later
         point_op = v + lv;
      end else if (op.do_sub && sel) begin
         // may go negative, floored later
         point_op = v - lv;
      end else begin
         point_op = v;
      end
   endfunction

   ////////////////////////////////////////
   // datapath
   ////////////////////////////////////////

   // luma approx 0.28 r + 0.56 g + 0.09 b
   // each term truncated on its own, max sum 234
   always_comb begin
      luma = widen(dec_i.pixel.red >> 2)
           + widen(dec_i.pixel.red >> 5)
           + widen(dec_i.pixel.green >> 1)
           + widen(dec_i.pixel.green >> 4)
           + widen(dec_i.pixel.blue >> 4)
           + widen(dec_i.pixel.blue >> 5);
   end

   always_comb begin
      rgb_nxt.red   = point_op(dec_i.pixel.red, dec_i.op.chan_sel[2],
                               dec_i.op, dec_i.level, luma);
      rgb_nxt.green = point_op(dec_i.pixel.green, dec_i.op.chan_sel[1],
                               dec_i.op, dec_i.level, luma);
      rgb_nxt.blue  = point_op(dec_i.pixel.blue, dec_i.op.chan_sel[0],
                               dec_i.op, dec_i.level, luma);
   end

   ////////////////////////////////////////
   // stage register
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         exe_o.valid <= 1'b0;
         exe_o.sync  <= '0;
      end else begin
         exe_o.valid <= dec_i.valid;
         exe_o.sync  <= dec_i.sync;
      end
   end

   // wide values, no clamping here
   always_ff @(posedge clock) begin
      exe_o.rgb <= rgb_nxt;
   end

endmodule

`default_nettype wire

//--- filter_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "pixel_filter_consts.svh"

module filter_result (
   input  wire logic                        clock,
   input  wire logic                        reset,
   input  wire pixel_filter_pkg::executed_t exe_i,
   output logic                             valid_o,
   output pixel_filter_pkg::sync_t          sync_o,
   output pixel_filter_pkg::rgb_out_t       rgb_o
);

   import pixel_filter_pkg::*;

   // clamped 8-bit channels
   chan_t    red_c;
   chan_t    green_c;
   chan_t    blue_c;
   // next output colour
   rgb_out_t rgb_nxt;

   ////////////////////////////////////////
   // saturation
   ////////////////////////////////////////

   // floor at 0, ceiling at 255
   function automatic chan_t clamp(input wide_t v);
      if (v < 0) begin
         clamp = '0;
      end else if (v > wide_t'(`PF_CHAN_MAX)) begin
         clamp = chan_t'(`PF_CHAN_MAX);
      end else begin
         clamp = chan_t'(v);
      end
   endfunction

   always_comb begin
      red_c   = clamp(exe_i.rgb.red);
      green_c = clamp(exe_i.rgb.green);
      blue_c  = clamp(exe_i.rgb.blue);
   end

   ////////////////////////////////////////
   // blanking and truncation
   ////////////////////////////////////////

   always_comb begin
      // keep the upper nibble of each channel
      rgb_nxt.red   = red_c[`PF_CHAN_W-1 -: `PF_OUT_W];
      rgb_nxt.green = green_c[`PF_CHAN_W-1 -: `PF_OUT_W];
      rgb_nxt.blue  = blue_c[`PF_CHAN_W-1 -: `PF_OUT_W];
      // outside the visible area the DAC must see black
      if (!exe_i.sync.blank_n) begin
         rgb_nxt = '0;
      end
   end

   ////////////////////////////////////////
   // output register
   ////////////////////////////////////////

   // sync stays aligned with its pixel, blanked or not
   always_ff @(posedge clock) begin
      if (reset) begin
         valid_o <= 1'b0;
         sync_o  <= '0;
         rgb_o   <= '0;
      end else begin
         valid_o <= exe_i.valid;
         sync_o  <= exe_i.sync;
         rgb_o   <= rgb_nxt;
      end
   end

endmodule

`default_nettype wire

//--- pixel_filter.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_filter (
   input  wire logic                      clock,
   input  wire logic                      reset,
   // pixel stream in, one pixel per valid cycle
   input  wire logic                      valid_i,
   input  wire pixel_filter_pkg::mode_t   mode_i,
   input  wire pixel_filter_pkg::chan_t   level_i,
   input  wire pixel_filter_pkg::rgb_t    pixel_i,
   input  wire pixel_filter_pkg::sync_t   sync_i,
   // filtered stream out, three cycles later
   output logic                           valid_o,
   output pixel_filter_pkg::sync_t        sync_o,
   output pixel_filter_pkg::rgb_out_t     rgb_o
);

   import pixel_filter_pkg::*;

   // stage to stage buses
   decoded_t  dec;
   executed_t exe;

   ////////////////////////////////////////
   // stage 1, mode decode
   ////////////////////////////////////////

   filter_decode u_decode (
      .clock   (clock),
      .reset   (reset),
      .valid_i (valid_i),
      .mode_i  (mode_i),
      .level_i (level_i),
      .pixel_i (pixel_i),
      .sync_i  (sync_i),
      .dec_o   (dec)
   );

   ////////////////////////////////////////
   // stage 2, arithmetic
   ////////////////////////////////////////

   // wide signed result, no saturation yet
   filter_execute u_execute (
      .clock (clock),
      .reset (reset),
      .dec_i (dec),
      .exe_o (exe)
   );

   ////////////////////////////////////////
   // stage 3, clamp and output
   ////////////////////////////////////////

   // saturate, blank, drop to 4 bits
   filter_result u_result (
      .clock   (clock),
      .reset   (reset),
      .exe_i   (exe),
      .valid_o (valid_o),
      .sync_o  (sync_o),
      .rgb_o   (rgb_o)
   );

endmodule

`default_nettype wire

//--- pixel_filter_sva.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_filter_sva (
   input wire logic                       clock,
   input wire logic                       reset,
   input wire logic                       valid_in_i,
   input wire logic                       valid_out_i,
   input wire pixel_filter_pkg::sync_t    sync_out_i,
   input wire pixel_filter_pkg::rgb_out_t rgb_out_i
);

   ////////////////////////////////////////
   // pipeline timing
   ////////////////////////////////////////

   // three register stages from valid_i to valid_o
   // only checked once three edges have passed outside reset
   valid_latency: assert property (
      @(posedge clock) disable iff (reset)
         (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
            |-> (valid_out_i == $past(valid_in_i, 3))
   ) else $error("valid_o does not follow valid_i by three cycles");

   // output stage cleared by reset
   valid_reset: assert property (
      @(posedge clock) reset |=> !valid_out_i
   ) else $error("valid_o high in the cycle after reset");

   ////////////////////////////////////////
   // blanking
   ////////////////////////////////////////

   // black towards the DAC outside the visible area
   blank_black: assert property (
      @(posedge clock) disable iff (reset)
         !sync_out_i.blank_n |-> (rgb_out_i == '0)
   ) else $error("colour output not zero while blank_n is low");

endmodule

bind pixel_filter pixel_filter_sva sva0 (
   .clock       (clock),
   .reset       (reset),
   .valid_in_i  (valid_i),
   .valid_out_i (valid_o),
   .sync_out_i  (sync_o),
   .rgb_out_i   (rgb_o)
);

`default_nettype wire

//--- pixel_filter_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pixel_filter_consts.svh"

module pixel_filter_tb;

   import pixel_filter_pkg::*;

   localparam int RESET_CYCLES = 3;
   localparam int LATENCY      = 3;

   // one stimulus row and its expected output
   typedef struct {
      string    name;
      mode_t    mode;
      chan_t    level;
      rgb_t     pixel;
      sync_t    sync;
      rgb_out_t exp_rgb;
      sync_t    exp_sync;
   } test_row_t;

   // pixel in flight, row index and entry cycle
   typedef struct packed {
      int row;
      int cycle;
   } pending_t;

   logic      clock;
   logic      reset;
   logic      valid_i;
   mode_t     mode_i;
   chan_t     level_i;
   rgb_t      pixel_i;
   sync_t     sync_i;
   logic      valid_o;
   sync_t     sync_o;
   rgb_out_t  rgb_o;

   test_row_t rows[$];
   pending_t  pending_q[$];
   int        cycle_count = 0;
   int        cycle_limit = 0;
   int        test_count = 0;
   int        fail_count = 0;
   int        error_count = 0;

   pixel_filter dut0 (
      .clock   (clock),
      .reset   (reset),
      .valid_i (valid_i),
      .mode_i  (mode_i),
      .level_i (level_i),
      .pixel_i (pixel_i),
      .sync_i  (sync_i),
      .valid_o (valid_o),
      .sync_o  (sync_o),
      .rgb_o   (rgb_o)
   );

   // 4 ns period
   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // floor 0, ceiling 255
   function automatic int limit_channel(input int v);
      if (v < 0) begin
         return 0;
      end else if (v > `PF_CHAN_MAX) begin
         return `PF_CHAN_MAX;
      end
      return v;
   endfunction

   function automatic rgb_out_t expected_colour(input mode_t mode, input chan_t level,
                                                input rgb_t pix, input sync_t sync);
      int       r;
      int       g;
      int       b;
      int       luma;
      rgb_out_t res;
      r = pix.red;
      g = pix.green;
      b = pix.blue;
      case (mode)
         `PF_MODE_GRAY: begin
            // every term truncated on its own
            luma = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
            r = luma;
            g = luma;
            b = luma;
         end
         `PF_MODE_BRIGHT: begin
            r = limit_channel(r + level);
            g = limit_channel(g + level);
            b = limit_channel(b + level);
         end
         `PF_MODE_DARK: begin
            r = limit_channel(r - level);
            g = limit_channel(g - level);
            b = limit_channel(b - level);
         end
         `PF_MODE_INVERT: begin
            r = `PF_CHAN_MAX - r;
            g = `PF_CHAN_MAX - g;
            b = `PF_CHAN_MAX - b;
         end
         `PF_MODE_RED:   r = limit_channel(r - level);
         `PF_MODE_BLUE:  b = limit_channel(b - level);
         `PF_MODE_GREEN: g = limit_channel(g - level);
         // 7 and the old codes 8..15 pass through
         default: ;
      endcase
      // upper nibble of each 8-bit result
      res.red   = out_chan_t'(r >> 4);
      res.green = out_chan_t'(g >> 4);
      res.blue  = out_chan_t'(b >> 4);
      if (!sync.blank_n) begin
         res = '0;
      end
      return res;
   endfunction

   task automatic add_row(input string name, input mode_t mode, input chan_t level,
                          input rgb_t pixel, input sync_t sync, input rgb_out_t exp_rgb,
                          input sync_t exp_sync);
      test_row_t row;
      row.name     = name;
      row.mode     = mode;
      row.level    = level;
      row.pixel    = pixel;
      row.sync     = sync;
      row.exp_rgb  = exp_rgb;
      row.exp_sync = exp_sync;
      rows.push_back(row);
   endtask

   ////////////////////////////////////////
   // output checker
   ////////////////////////////////////////

   task automatic check_output(input pending_t p);
      test_row_t row;
      int        errs;
      int        latency;
      row = rows[p.row];
      errs = 0;
      latency = cycle_count - p.cycle;
      assert (rgb_o == row.exp_rgb) else begin
         $display("[ERROR] %s rgb expected %h actual %h", row.name, row.exp_rgb, rgb_o);
         errs++;
      end
      assert (sync_o == row.exp_sync) else begin
         $display("[ERROR] %s sync expected %b actual %b", row.name, row.exp_sync, sync_o);
         errs++;
      end
      // exactly three cycles in the pipe
      assert (latency == LATENCY) else begin
         $display("%s came out %0d cycles after entry instead of 3", row.name, latency);
         errs++;
      end
      test_count++;
      if (errs == 0) begin
         $display("ok     %s", row.name);
      end else begin
         fail_count++;
         $display("failed %s", row.name);
      end
      error_count += errs;
   endtask

   // outputs settled since the rising edge
   always @(negedge clock) begin
      if (!reset && valid_o) begin
         assert (pending_q.size() != 0) else begin
            $display("valid_o went high with no pixel in flight");
            error_count++;
         end
         if (pending_q.size() != 0) begin
            check_output(pending_q.pop_front());
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      int       i;
      rgb_t     pix;
      sync_t    snc;
      mode_t    md;
      chan_t    lvl;
      pending_t p;
      void'($urandom(9));
      reset = 1'b1;
      // a live white visible pixel all through reset
      // only the reset keeps the outputs at zero
      valid_i = 1'b1;
      mode_i = `PF_MODE_PASS;
      level_i = '0;
      pixel_i = '1;
      sync_i = '1;

      // pixel is blue green red, expected colour is red green blue
      add_row("gray_mix", `PF_MODE_GRAY, 8'h00, 24'h204080, 3'b001, 12'h444, 3'b001);
      add_row("gray_white", `PF_MODE_GRAY, 8'h00, 24'hFFFFFF, 3'b001, 12'hEEE, 3'b001);
      add_row("pass_mode7", `PF_MODE_PASS, 8'h33, 24'h563412, 3'b001, 12'h135, 3'b001);
      add_row("pass_mode12", 4'd12, 8'h33, 24'hEFCDAB, 3'b001, 12'hACE, 3'b001);
      add_row("bright_sat", `PF_MODE_BRIGHT, 8'd10, 24'hFAFAFA, 3'b001, 12'hFFF, 3'b001);
      add_row("bright_range", `PF_MODE_BRIGHT, 8'h20, 24'h704010, 3'b001, 12'h369, 3'b001);
      add_row("dark_clamp", `PF_MODE_DARK, 8'd10, 24'h050505, 3'b001, 12'h000, 3'b001);
      add_row("dark_range", `PF_MODE_DARK, 8'h20, 24'h306090, 3'b001, 12'h741, 3'b001);
      add_row("invert", `PF_MODE_INVERT, 8'h00, 24'hFF0030, 3'b001, 12'hCF0, 3'b001);
      add_row("red_filter", `PF_MODE_RED, 8'h40, 24'h808080, 3'b001, 12'h488, 3'b001);
      add_row("red_floor", `PF_MODE_RED, 8'h50, 24'hA09020, 3'b001, 12'h09A, 3'b001);
      add_row("blue_filter", `PF_MODE_BLUE, 8'h40, 24'h808080, 3'b001, 12'h884, 3'b001);
      add_row("green_filter", `PF_MODE_GREEN, 8'h40, 24'h808080, 3'b001, 12'h848, 3'b001);
      add_row("green_floor", `PF_MODE_GREEN, 8'hFF, 24'h10F0F0, 3'b001, 12'hF01, 3'b001);
      // hsync vsync blank_n
      add_row("blank_hsync", `PF_MODE_PASS, 8'h00, 24'hFFFFFF, 3'b100, 12'h000, 3'b100);
      add_row("blank_vsync", `PF_MODE_BRIGHT, 8'd5, 24'h123456, 3'b010, 12'h000, 3'b010);
      add_row("sync_visible", `PF_MODE_INVERT, 8'h00, 24'h000000, 3'b101, 12'hFFF, 3'b101);

      // random rows over modes 0..7
      for (i = 0; i < 16; i++) begin
         pix = rgb_t'($urandom);
         lvl = chan_t'($urandom);
         md  = mode_t'($urandom % 8);
         snc = sync_t'($urandom);
         add_row($sformatf("random_%0d", i), md, lvl, pix, snc,
                 expected_colour(md, lvl, pix, snc), snc);
      end
      cycle_limit = rows.size() + RESET_CYCLES + LATENCY + 20;

      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      test_count++;
      assert (valid_o == 1'b0 && sync_o == '0 && rgb_o == '0) begin
         $display("ok     reset_clear");
      end else begin
         $display("[ERROR] reset_clear outputs expected 0 actual valid %b sync %b rgb %h",
                  valid_o, sync_o, rgb_o);
         fail_count++;
         error_count++;
      end

      // back to back, one row per cycle
      for (i = 0; i < rows.size(); i++) begin
         valid_i = 1'b1;
         mode_i  = rows[i].mode;
         level_i = rows[i].level;
         pixel_i = rows[i].pixel;
         sync_i  = rows[i].sync;
         p.row   = i;
         p.cycle = cycle_count;
         pending_q.push_back(p);
         @(negedge clock);
      end
      valid_i = 1'b0;

      // drain the pipe, bounded by the cycle limit
      while (pending_q.size() != 0 && cycle_count < cycle_limit) begin
         @(negedge clock);
      end
      repeat (2) @(negedge clock);
      if (pending_q.size() != 0) begin
         $display("timeout: %0d pixels never came out of the filter", pending_q.size());
         error_count++;
      end

      $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- pixel_filter.f
+incdir+.
pixel_filter_pkg.sv
filter_decode.sv
filter_execute.sv
filter_result.sv
pixel_filter.sv
pixel_filter_sva.sv
pixel_filter_tb.sv
